// ==== design/mac_tx_defines.svh ====
`ifndef MAC_TX_DEFINES_SVH
`define MAC_TX_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// line format
//////////////////////////////////////////////////////////////////////

`define MAC_PREAMBLE_BYTE    8'h55
`define MAC_SFD_BYTE         8'hD5
`define MAC_PREAMBLE_LEN     7      // preamble bytes before the sfd
`define MAC_MIN_PAYLOAD      60     // shorter payloads get zero pad
`define MAC_FCS_LEN          4
`define MAC_IFG_CYCLES       12     // idle cycles between frames

// length field of the source pointer and line descriptor
`define MAC_LEN_W            11

//////////////////////////////////////////////////////////////////////
// buffering
//////////////////////////////////////////////////////////////////////

`define MAC_FRAME_FIFO_DEPTH 4096
`define MAC_DESC_FIFO_DEPTH  32

// largest frame on the line, a new frame needs this much room
`define MAC_MAX_LINE_BYTES   1530

`endif

// ==== design/mac_tx_pkg.sv ====
package mac_tx_pkg;

`include "mac_tx_defines.svh"

    // one queued source as seen by the mac
    typedef struct packed {
        logic [15:0] ptr;        // payload length in the low bits
        logic        ptr_empty;
        logic [7:0]  data;
    } mac_src_in_t;

    // read strobes back to one source
    typedef struct packed {
        logic ptr_rd;
        logic data_rd;
    } mac_src_rd_t;

    // one octet of the frame stream
    typedef logic [7:0] mac_frame_byte_t;

    // frame handed to the line side
    typedef struct packed {
        logic                  gbit;       // gmii when set, mii nibbles otherwise
        logic [`MAC_LEN_W-1:0] line_len;   // padded payload + 12
    } mac_line_desc_t;

    // arbiter to framer
    typedef struct packed {
        logic                  start;      // single cycle
        logic                  tte;
        logic [`MAC_LEN_W-1:0] len;
    } mac_frame_req_t;

endpackage

// ==== design/crc32_8023.sv ====
`timescale 1ns/10ps

module crc32_8023 import mac_tx_pkg::*; (
    input  logic            tx_master_clk,
    input  logic            rstn_mac,
    input  logic            load_init,
    input  logic            calc,
    input  logic            shift_out,
    input  mac_frame_byte_t d,
    output mac_frame_byte_t fcs_byte
);

    logic [31:0] crc_reg;

    // reflected 802.3 polynomial, lsb of the byte first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            r = (r[0] ^ b[i]) ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            crc_reg <= '1;
        end else if (load_init) begin
            crc_reg <= '1;
        end else if (calc) begin
            crc_reg <= crc_step(crc_reg, d);
        end else if (shift_out) begin
            crc_reg <= {8'hFF, crc_reg[31:8]};   // next fcs byte into the low end
        end
    end

    assign fcs_byte = ~crc_reg[7:0];

endmodule

// ==== design/mac_tx_sync_fifo.sv ====
`timescale 1ns/10ps

module mac_tx_sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16
) (
    input  logic                     tx_master_clk,
    input  logic                     rstn_mac,
    input  logic                     wr,
    input  payload_t                 din,
    input  logic                     rd,
    output payload_t                 dout,
    output logic [$clog2(depth):0]   count,
    output logic                     full,
    output logic                     empty
);

    localparam int aw = $clog2(depth);

    payload_t        mem [depth];
    logic [aw-1:0]   wr_ptr;
    logic [aw-1:0]   rd_ptr;
    logic            do_wr;
    logic            do_rd;

    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;
    assign full  = count == depth;
    assign empty = count == '0;

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge tx_master_clk) begin
        if (do_wr) mem[wr_ptr] <= din;
        if (do_rd) dout <= mem[rd_ptr];   // one cycle read latency
    end

    no_overflow: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        !(wr && full));
    no_underflow: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        !(rd && empty));

endmodule

// ==== design/mac_tx_src_arbiter.sv ====
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module mac_tx_src_arbiter import mac_tx_pkg::*; (
    input  logic            tx_master_clk,
    input  logic            rstn_mac,
    input  mac_src_in_t     normal_src,
    input  mac_src_in_t     tte_src,
    output mac_src_rd_t     normal_rd,
    output mac_src_rd_t     tte_rd,
    input  logic            ready,
    input  logic            frame_busy,
    input  logic            byte_req,
    output mac_frame_req_t  req,
    output mac_frame_byte_t payload_byte
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_PTR,     // ptr_rd out to the winner
        ARB_WAIT     // ptr comes back from the source
    } arb_state_t;

    arb_state_t state;
    logic       sel_tte;     // latched winner
    logic       any_waiting;

    assign any_waiting = !tte_src.ptr_empty || !normal_src.ptr_empty;

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state   <= ARB_IDLE;
            sel_tte <= 1'b0;
            req     <= '0;
        end else begin
            req.start <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (!frame_busy && ready && any_waiting) begin
                        sel_tte <= !tte_src.ptr_empty;   // tte wins a tie
                        state   <= ARB_PTR;
                    end
                end
                ARB_PTR: state <= ARB_WAIT;
                ARB_WAIT: begin
                    req.start <= 1'b1;
                    req.tte   <= sel_tte;
                    req.len   <= sel_tte ? tte_src.ptr[`MAC_LEN_W-1:0]
                                         : normal_src.ptr[`MAC_LEN_W-1:0];
                    state     <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // strobes steered to the latched source
    assign tte_rd.ptr_rd     = (state == ARB_PTR) && sel_tte;
    assign normal_rd.ptr_rd  = (state == ARB_PTR) && !sel_tte;
    assign tte_rd.data_rd    = byte_req && sel_tte;
    assign normal_rd.data_rd = byte_req && !sel_tte;

    assign payload_byte = sel_tte ? tte_src.data : normal_src.data;   // source has 1 cycle latency

    // a descriptor read only goes to a source that holds one
    ptr_rd_not_empty: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        !(tte_rd.ptr_rd && tte_src.ptr_empty) &&
        !(normal_rd.ptr_rd && normal_src.ptr_empty));

endmodule

// ==== design/mac_tx_framer.sv ====
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module mac_tx_framer import mac_tx_pkg::*; (
    input  logic                                   tx_master_clk,
    input  logic                                   rstn_mac,
    input  logic                                   gbit_mode,
    input  mac_frame_req_t                         req,
    input  mac_frame_byte_t                        payload_byte,
    output logic                                   byte_req,
    output logic                                   frame_busy,
    output logic                                   ready,
    input  logic [$clog2(`MAC_FRAME_FIFO_DEPTH):0] frame_count,
    input  logic                                   desc_full,
    output logic                                   frame_wr,
    output mac_frame_byte_t                        frame_byte,
    output logic                                   desc_wr,
    output mac_line_desc_t                         desc
);

    typedef enum logic [2:0] {
        FR_IDLE,
        FR_PRE,        // 7 preamble bytes and the sfd
        FR_DATA,
        FR_PAD,
        FR_FCS_WAIT,   // crc settles
        FR_FCS
    } fr_state_t;

    fr_state_t             state;
    logic [`MAC_LEN_W-1:0] loop_cnt;
    logic [`MAC_LEN_W-1:0] len_q;
    logic [`MAC_LEN_W-1:0] padded_len;
    logic                  gbit_q;
    logic                  short_frame;
    mac_frame_byte_t       byte_nxt;
    mac_frame_byte_t       fcs_byte;

    assign short_frame = len_q < `MAC_MIN_PAYLOAD;
    assign padded_len  = short_frame ? `MAC_LEN_W'(`MAC_MIN_PAYLOAD) : len_q;

    //////////////////////////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state    <= FR_IDLE;
            loop_cnt <= '0;
            frame_wr <= 1'b0;
            desc_wr  <= 1'b0;
        end else begin
            frame_wr <= state inside {FR_PRE, FR_DATA, FR_PAD, FR_FCS};
            desc_wr  <= 1'b0;
            loop_cnt <= loop_cnt - 1'b1;
            case (state)
                FR_IDLE: begin
                    if (req.start) begin
                        state    <= FR_PRE;
                        loop_cnt <= `MAC_LEN_W'(`MAC_PREAMBLE_LEN);
                    end
                end
                FR_PRE: begin
                    if (loop_cnt == '0 && len_q != '0) begin
                        state    <= FR_DATA;
                        loop_cnt <= len_q - 1'b1;
                    end else if (loop_cnt == '0) begin
                        state    <= FR_PAD;   // empty payload, all pad
                        loop_cnt <= `MAC_LEN_W'(`MAC_MIN_PAYLOAD - 1);
                    end
                end
                FR_DATA: begin
                    if (loop_cnt == '0 && short_frame) begin
                        state    <= FR_PAD;
                        loop_cnt <= `MAC_LEN_W'(`MAC_MIN_PAYLOAD - 1) - len_q;
                    end else if (loop_cnt == '0) begin
                        state <= FR_FCS_WAIT;
                    end
                end
                FR_PAD: begin
                    if (loop_cnt == '0) begin
                        state <= FR_FCS_WAIT;
                    end
                end
                FR_FCS_WAIT: begin
                    state    <= FR_FCS;
                    loop_cnt <= `MAC_LEN_W'(`MAC_FCS_LEN - 1);
                end
                FR_FCS: begin
                    if (loop_cnt == '0) begin
                        state   <= FR_IDLE;
                        desc_wr <= 1'b1;   // lands with the last fcs byte
                    end
                end
                default: state <= FR_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state)
            FR_PRE:  byte_nxt = (loop_cnt == '0) ? `MAC_SFD_BYTE : `MAC_PREAMBLE_BYTE;
            FR_DATA: byte_nxt = payload_byte;
            FR_FCS:  byte_nxt = fcs_byte;
            default: byte_nxt = '0;   // pad
        endcase
    end

    always_ff @(posedge tx_master_clk) begin
        frame_byte <= byte_nxt;
        if (state == FR_IDLE && req.start) begin
            len_q  <= req.len;
            gbit_q <= gbit_mode;   // speed travels with the frame
        end
        if (state == FR_FCS && loop_cnt == '0) begin
            desc.gbit     <= gbit_q;
            desc.line_len <= padded_len + `MAC_LEN_W'(`MAC_PREAMBLE_LEN + 1 + `MAC_FCS_LEN);
        end
    end

    // one read ahead, stops after len bytes
    assign byte_req = (state == FR_PRE && loop_cnt == '0 && len_q != '0) ||
                      (state == FR_DATA && loop_cnt != '0);

    assign frame_busy = (state != FR_IDLE) || req.start;
    assign ready      = (frame_count <= `MAC_FRAME_FIFO_DEPTH - `MAC_MAX_LINE_BYTES) && !desc_full;

    crc32_8023 u_crc (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .load_init     (state == FR_IDLE && req.start),
        .calc          (state inside {FR_DATA, FR_PAD}),
        .shift_out     (state == FR_FCS),
        .d             (byte_nxt),
        .fcs_byte      (fcs_byte)
    );

    frame_fifo_room: assert property (@(posedge tx_master_clk) disable iff (!rstn_mac)
        frame_wr |-> frame_count < `MAC_FRAME_FIFO_DEPTH);

endmodule

// ==== design/mac_tx_mii_serializer.sv ====
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module mac_tx_mii_serializer import mac_tx_pkg::*; (
    input  logic            tx_master_clk,
    input  logic            rstn_mac,
    input  mac_line_desc_t  desc,
    input  logic            desc_empty,
    output logic            desc_rd,
    input  mac_frame_byte_t frame_byte,
    output logic            frame_rd,
    output logic            gtx_dv,
    output logic [7:0]      gtx_d
);

    typedef enum logic [2:0] {
        SER_IDLE,
        SER_FETCH,    // descriptor valid, first byte requested
        SER_GMII,
        SER_MII_LO,
        SER_MII_HI,
        SER_GAP
    } ser_state_t;

    ser_state_t            state;
    logic [`MAC_LEN_W-1:0] cnt;   // bytes left, then gap cycles

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state <= SER_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                SER_IDLE: begin
                    if (!desc_empty) state <= SER_FETCH;
                end
                SER_FETCH: begin
                    cnt   <= desc.line_len;
                    state <= desc.gbit ? SER_GMII : SER_MII_LO;
                end
                SER_GMII, SER_MII_HI: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == `MAC_LEN_W'(1)) begin
                        state <= SER_GAP;
                        cnt   <= `MAC_LEN_W'(`MAC_IFG_CYCLES);
                    end else if (state == SER_MII_HI) begin
                        state <= SER_MII_LO;
                    end
                end
                SER_MII_LO: state <= SER_MII_HI;
                SER_GAP: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == `MAC_LEN_W'(1)) state <= SER_IDLE;
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    assign desc_rd = (state == SER_IDLE) && !desc_empty;

    // byte fetched a cycle ahead, held across both nibbles
    assign frame_rd = (state == SER_FETCH) ||
                      ((state == SER_GMII || state == SER_MII_HI) && cnt != `MAC_LEN_W'(1));

    //////////////////////////////////////////////////////////////////////
    // line drivers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            gtx_dv <= 1'b0;
            gtx_d  <= '0;
        end else begin
            gtx_dv <= state inside {SER_GMII, SER_MII_LO, SER_MII_HI};
            case (state)
                SER_GMII:   gtx_d <= frame_byte;
                SER_MII_LO: gtx_d <= {4'b0, frame_byte[3:0]};   // low nibble first
                SER_MII_HI: gtx_d <= {4'b0, frame_byte[7:4]};
                default:    gtx_d <= '0;
            endcase
        end
    end

endmodule

// ==== design/mac_tx_top.sv ====
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module mac_tx_top import mac_tx_pkg::*; (
    input  logic        tx_master_clk,
    input  logic        rstn_mac,
    input  logic        gbit_mode,
    input  mac_src_in_t normal_src,
    input  mac_src_in_t tte_src,
    output mac_src_rd_t normal_rd,
    output mac_src_rd_t tte_rd,
    output logic        gtx_dv,
    output logic [7:0]  gtx_d
);

    mac_frame_req_t                         req;
    mac_frame_byte_t                        payload_byte;
    logic                                   byte_req;
    logic                                   frame_busy;
    logic                                   ready;
    logic [$clog2(`MAC_FRAME_FIFO_DEPTH):0] frame_count;
    logic                                   frame_wr;
    logic                                   frame_rd;
    mac_frame_byte_t                        frame_wdata;
    mac_frame_byte_t                        frame_rdata;
    logic                                   desc_wr;
    logic                                   desc_rd;
    logic                                   desc_full;
    logic                                   desc_empty;
    mac_line_desc_t                         desc_wdata;
    mac_line_desc_t                         desc_rdata;

    mac_tx_src_arbiter u_arbiter (
        .tx_master_clk, .rstn_mac, .normal_src, .tte_src, .normal_rd, .tte_rd,
        .ready, .frame_busy, .byte_req, .req, .payload_byte
    );

    mac_tx_framer u_framer (
        .tx_master_clk, .rstn_mac, .gbit_mode, .req, .payload_byte, .byte_req,
        .frame_busy, .ready, .frame_count, .desc_full,
        .frame_wr   (frame_wr),
        .frame_byte (frame_wdata),
        .desc_wr    (desc_wr),
        .desc       (desc_wdata)
    );

    mac_tx_sync_fifo #(.payload_t(mac_frame_byte_t), .depth(`MAC_FRAME_FIFO_DEPTH)) frame_fifo (
        .tx_master_clk, .rstn_mac,
        .wr (frame_wr), .din (frame_wdata), .rd (frame_rd), .dout (frame_rdata),
        .count (frame_count), .full (), .empty ()
    );

    mac_tx_sync_fifo #(.payload_t(mac_line_desc_t), .depth(`MAC_DESC_FIFO_DEPTH)) desc_fifo (
        .tx_master_clk, .rstn_mac,
        .wr (desc_wr), .din (desc_wdata), .rd (desc_rd), .dout (desc_rdata),
        .count (), .full (desc_full), .empty (desc_empty)
    );

    mac_tx_mii_serializer u_serializer (
        .tx_master_clk, .rstn_mac,
        .desc (desc_rdata), .desc_empty, .desc_rd,
        .frame_byte (frame_rdata), .frame_rd, .gtx_dv, .gtx_d
    );

endmodule

// ==== sim/tb_mac_tx.sv ====
`timescale 1ns/10ps
`include "mac_tx_defines.svh"

module tb_mac_tx import mac_tx_pkg::*; ();

    localparam int max_frames = 64;

    logic        tx_master_clk;
    logic        rstn_mac;
    logic        gbit_mode;
    mac_src_in_t src_in [2];    // 0 normal, 1 tte
    mac_src_rd_t src_rd [2];
    logic        gtx_dv;
    logic [7:0]  gtx_d;

    // frame table from the stimulus file
    int          n_frames = 0;
    int          f_src   [max_frames];
    int          f_len   [max_frames];
    logic        f_gbit  [max_frames];
    logic [7:0]  f_first [max_frames];
    logic [31:0] f_fcs   [max_frames];

    logic [31:0] crc_table [256];
    int          frame_q [2][$];    // descriptors waiting in each source
    logic [7:0]  byte_q  [2][$];    // payload behind the last descriptor read
    int          exp_q   [$];       // expected line order
    integer      seed = 32'h7fff_5d8b;
    int          errors = 0;
    int          frames_done = 0;
    int          frames_ok = 0;
    int          src_f;
    longint      cycles = 0;
    longint      cycle_limit = 0;

    // line monitor state
    logic        in_frame = 1'b0;
    logic        seen_frame = 1'b0;
    logic        nib_hi;
    logic [3:0]  nib_lo;
    int          cur = 0;
    int          dv_cycles;
    int          idle_cycles = 0;
    int          err_at_start;
    logic [7:0]  rx [$];

    mac_tx_top dut (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .gbit_mode     (gbit_mode),
        .normal_src    (src_in[0]),
        .tte_src       (src_in[1]),
        .normal_rd     (src_rd[0]),
        .tte_rd        (src_rd[1]),
        .gtx_dv        (gtx_dv),
        .gtx_d         (gtx_d)
    );

    initial begin
        tx_master_clk = 1'b0;
        forever #5 tx_master_clk = ~tx_master_clk;
    end

    function automatic int padded(input int f);
        return (f_len[f] < `MAC_MIN_PAYLOAD) ? `MAC_MIN_PAYLOAD : f_len[f];
    endfunction

    // table driven 802.3 fcs over payload and pad
    function automatic logic [31:0] model_fcs(input int f);
        logic [31:0] c;
        logic [7:0]  b;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < padded(f); i++) begin
            b = (i < f_len[f]) ? f_first[f] + 8'(i) : 8'h00;
            c = crc_table[c[7:0] ^ b] ^ (c >> 8);
        end
        return ~c;
    endfunction

    // octet i of frame f as it should appear on the line
    function automatic logic [7:0] line_byte(input int f, input int i);
        int p;
        p = padded(f);
        if (i < `MAC_PREAMBLE_LEN) return `MAC_PREAMBLE_BYTE;
        if (i == `MAC_PREAMBLE_LEN) return `MAC_SFD_BYTE;
        if (i < 8 + f_len[f]) return f_first[f] + 8'(i - 8);
        if (i < 8 + p) return 8'h00;
        return 8'(f_fcs[f] >> (8 * (i - 8 - p)));   // lsb first
    endfunction

    task automatic build_crc_table();
        logic [31:0] c;
        for (int n = 0; n < 256; n++) begin
            c = 32'(n);
            repeat (8) begin
                c = c[0] ? (c >> 1) ^ 32'hEDB8_8320 : c >> 1;
            end
            crc_table[n] = c;
        end
    endtask

    // known crc-32 of the ascii string 123456789
    task automatic check_crc_model();
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < 9; i++) begin
            c = crc_table[c[7:0] ^ (8'h31 + 8'(i))] ^ (c >> 8);
        end
        assert (~c == 32'hCBF4_3926) else begin
            $display("the crc model gives %h for the standard check string", ~c);
            errors++;
        end
    endtask

    task automatic read_stimulus();
        int          fd;
        int          s;
        int          g;
        int          l;
        int          b;
        logic [31:0] fcs;
        string       line;
        fd = $fopen("sim/mac_tx_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file sim/mac_tx_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_frames < max_frames) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%d %d %d %h %h", s, g, l, b, fcs) == 5) begin
                    f_src[n_frames]   = s;
                    f_gbit[n_frames]  = g[0];
                    f_len[n_frames]   = l;
                    f_first[n_frames] = b[7:0];
                    f_fcs[n_frames]   = (fcs != 0) ? fcs : model_fcs(n_frames);
                    cycle_limit += 2 * (padded(n_frames) + 12) + 40;
                    n_frames++;
                end
            end
            $fclose(fd);
            cycle_limit += 200;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // source fifo models with one cycle of read latency
    //////////////////////////////////////////////////////////////////////

    always @(posedge tx_master_clk) begin
        for (int s = 0; s < 2; s++) begin
            if (rstn_mac && src_rd[s].ptr_rd) begin
                assert (frame_q[s].size() != 0) else begin
                    $display("descriptor read from source %0d while it was empty", s);
                    errors++;
                end
                assert (byte_q[s].size() == 0) else begin
                    $display("source %0d: payload bytes left unread at the next descriptor", s);
                    errors++;
                end
                if (frame_q[s].size() != 0) begin
                    src_f = frame_q[s].pop_front();
                    src_in[s].ptr <= {5'(src_f), 11'(f_len[src_f])};
                    gbit_mode <= f_gbit[src_f];   // speed follows the frame
                    byte_q[s].delete();
                    for (int i = 0; i < f_len[src_f]; i++) begin
                        byte_q[s].push_back(f_first[src_f] + 8'(i));
                    end
                end
            end
            if (rstn_mac && src_rd[s].data_rd) begin
                assert (byte_q[s].size() != 0) else begin
                    $display("source %0d saw a data read past the end of its payload", s);
                    errors++;
                end
                if (byte_q[s].size() != 0) begin
                    src_in[s].data <= byte_q[s].pop_front();
                end
            end
            src_in[s].ptr_empty <= (frame_q[s].size() == 0);
        end
    end

    // a normal line followed by a tte line goes in as a pair
    task automatic queue_frames();
        int k;
        int gap;
        k = 0;
        while (k < n_frames) begin
            while (frame_q[0].size() != 0 || frame_q[1].size() != 0) begin
                @(negedge tx_master_clk);
            end
            gap = $random(seed) & 7;
            repeat (gap + 1) @(negedge tx_master_clk);
            if (k + 1 < n_frames && f_src[k] == 0 && f_src[k + 1] == 1) begin
                frame_q[0].push_back(k);
                frame_q[1].push_back(k + 1);
                exp_q.push_back(k + 1);   // tte wins
                exp_q.push_back(k);
                k += 2;
            end else begin
                frame_q[f_src[k]].push_back(k);
                exp_q.push_back(k);
                k++;
            end
        end
    endtask

    task automatic check_frame();
        int   l;
        logic bad;
        l = padded(cur) + 12;
        bad = 1'b0;
        assert (dv_cycles == (f_gbit[cur] ? l : 2 * l)) else begin
            $display("FAIL %0t: frame %0d gtx_dv high %0d cycles, expected %0d",
                     $time, cur, dv_cycles, f_gbit[cur] ? l : 2 * l);
            errors++;
        end
        assert (rx.size() == l) else begin
            $display("FAIL %0t: frame %0d has %0d octets, expected %0d", $time, cur, rx.size(), l);
            errors++;
        end
        for (int i = 0; i < rx.size() && !bad; i++) begin
            assert (rx[i] == line_byte(cur, i)) else begin
                $display("FAIL %0t: frame %0d octet %0d is %h, expected %h",
                         $time, cur, i, rx[i], line_byte(cur, i));
                errors++;
                bad = 1'b1;   // first mismatch is enough
            end
        end
        frames_done++;
        seen_frame = 1'b1;
        if (errors == err_at_start) frames_ok++;
        $display("frame %0d, %s, %s, %0d payload bytes: %s", cur, f_src[cur] ? "tte" : "normal",
                 f_gbit[cur] ? "gmii" : "mii", f_len[cur], (errors == err_at_start) ? "ok" : "error");
    endtask

    //////////////////////////////////////////////////////////////////////
    // line monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge tx_master_clk) begin
        if (rstn_mac && gtx_dv) begin
            if (!in_frame) begin
                err_at_start = errors;
                assert (!seen_frame || idle_cycles >= `MAC_IFG_CYCLES) else begin
                    $display("FAIL %0t: only %0d idle cycles before a frame", $time, idle_cycles);
                    errors++;
                end
                assert (exp_q.size() != 0) else begin
                    $display("a frame appeared on the line when none was expected");
                    errors++;
                end
                if (exp_q.size() != 0) cur = exp_q.pop_front();
                in_frame = 1'b1;
                dv_cycles = 0;
                nib_hi = 1'b0;
                rx.delete();
            end
            dv_cycles++;
            if (f_gbit[cur]) begin
                rx.push_back(gtx_d);
            end else begin
                assert (gtx_d[7:4] == 4'h0) else begin
                    $display("FAIL %0t: frame %0d mii upper bits are %h", $time, cur, gtx_d[7:4]);
                    errors++;
                end
                if (nib_hi) rx.push_back({gtx_d[3:0], nib_lo});   // low nibble came first
                nib_lo = gtx_d[3:0];
                nib_hi = !nib_hi;
            end
        end else if (in_frame) begin
            check_frame();
            in_frame = 1'b0;
            idle_cycles = 1;
        end else begin
            idle_cycles++;
        end
    end

    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge tx_master_clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d frames checked",
                 cycles, frames_done, n_frames);
        $display("tests failed");
        $finish;
    end

    initial begin
        rstn_mac <= 1'b0;
        gbit_mode <= 1'b1;
        for (int s = 0; s < 2; s++) begin
            src_in[s] <= {16'h0000, 1'b1, 8'h00};
        end
        build_crc_table();
        check_crc_model();
        read_stimulus();
        repeat (2) @(posedge tx_master_clk);
        rstn_mac <= 1'b1;
        queue_frames();
        while (frames_done < n_frames) @(posedge tx_master_clk);
        assert (byte_q[0].size() == 0 && byte_q[1].size() == 0) else begin
            $display("payload bytes were left unread in a source");
            errors++;
        end
        $display("summary: %0d frames checked, %0d ok, %0d errors", frames_done, frames_ok, errors);
        if (errors == 0 && n_frames > 0 && frames_ok == n_frames) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sim/mac_tx_stimulus.txt ====
# columns: src (0 normal, 1 tte)  gbit (1 gmii, 0 mii)  payload length  first byte (hex)
#          expected fcs (hex, 00000000 takes the testbench crc model)
# payload bytes count up from the first byte
# a normal line directly followed by a tte line is queued in the same cycle
1 1   64 00 00000000
1 0   46 a0 00000000
0 1   60 10 00000000
0 0    0 00 00000000   # all pad
0 1    1 7f 00000000
0 1   59 c3 00000000
0 0   61 fe 00000000   # pair with the next line
1 1  100 20 00000000
1 1 1500 55 00000000   # largest payload
1 0   17 e0 00000000
0 1  256 00 00000000
0 1  300 80 00000000   # pair with the next line
1 0   72 41 00000000
1 1   45 9a 00000000
0 0  128 f0 00000000
0 1 1024 01 00000000

// ==== build.f ====
+incdir+design
design/mac_tx_pkg.sv
design/crc32_8023.sv
design/mac_tx_sync_fifo.sv
design/mac_tx_src_arbiter.sv
design/mac_tx_framer.sv
design/mac_tx_mii_serializer.sv
design/mac_tx_top.sv
sim/tb_mac_tx.sv
